/* list.f */
+incdir+rtl
rtl/mempool_pkg.sv
rtl/mempool_host_port.sv
rtl/mempool_interco.sv
rtl/mempool_tile.sv
rtl/mempool.sv
test/mempool_asserts.sv
test/tb_mempool.sv

/* rtl/mempool.sv */
/*
 * MemPool cluster top. Host ports, the interleaving interconnect
 * and the memory tiles
 */
`timescale 1ns/1ps
`default_nettype none
`include "mempool_cfg.svh"

module mempool (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic               [`MEMPOOL_NUM_HOSTS-1:0]  req_i,
  output logic               [`MEMPOOL_NUM_HOSTS-1:0]  ack_o,
  input  logic               [`MEMPOOL_NUM_HOSTS-1:0]  wen_i,
  input  mempool_pkg::addr_t [`MEMPOOL_NUM_HOSTS-1:0]  addr_i,
  input  mempool_pkg::data_t [`MEMPOOL_NUM_HOSTS-1:0]  wdata_i,
  input  mempool_pkg::strb_t [`MEMPOOL_NUM_HOSTS-1:0]  be_i,
  output mempool_pkg::data_t [`MEMPOOL_NUM_HOSTS-1:0]  rdata_o
);

  import mempool_pkg::*;

  localparam int unsigned NumHosts = `MEMPOOL_NUM_HOSTS;
  localparam int unsigned NumTiles = `MEMPOOL_NUM_TILES;
  localparam int unsigned NumBanks = `MEMPOOL_BANKS_PER_TILE;

  // Host ports to interconnect
  logic       [NumHosts-1:0] hreq_valid;
  logic       [NumHosts-1:0] hreq_ready;
  addr_t      [NumHosts-1:0] hreq_addr;
  logic       [NumHosts-1:0] hreq_wen;
  data_t      [NumHosts-1:0] hreq_wdata;
  strb_t      [NumHosts-1:0] hreq_be;
  logic       [NumHosts-1:0] hresp_valid;
  data_t      [NumHosts-1:0] hresp_rdata;
  // Interconnect to tiles
  logic       [NumTiles-1:0] treq_valid;
  logic       [NumTiles-1:0] treq_ready;
  tile_addr_t [NumTiles-1:0] treq_addr;
  ini_addr_t  [NumTiles-1:0] treq_ini;
  logic       [NumTiles-1:0] treq_wen;
  data_t      [NumTiles-1:0] treq_wdata;
  strb_t      [NumTiles-1:0] treq_be;
  logic       [NumTiles-1:0] tresp_valid;
  ini_addr_t  [NumTiles-1:0] tresp_ini;
  data_t      [NumTiles-1:0] tresp_rdata;

  for (genvar h = 0; h < NumHosts; h++) begin : gen_hosts
    mempool_host_port i_host_port (
      .clk_i         (clk_i         ),
      .rst_n_i       (rst_n_i       ),
      .req_i         (req_i[h]      ),
      .ack_o         (ack_o[h]      ),
      .wen_i         (wen_i[h]      ),
      .addr_i        (addr_i[h]     ),
      .wdata_i       (wdata_i[h]    ),
      .be_i          (be_i[h]       ),
      .rdata_o       (rdata_o[h]    ),
      .hreq_valid_o  (hreq_valid[h] ),
      .hreq_ready_i  (hreq_ready[h] ),
      .hreq_addr_o   (hreq_addr[h]  ),
      .hreq_wen_o    (hreq_wen[h]   ),
      .hreq_wdata_o  (hreq_wdata[h] ),
      .hreq_be_o     (hreq_be[h]    ),
      .hresp_valid_i (hresp_valid[h]),
      .hresp_rdata_i (hresp_rdata[h])
    );
  end : gen_hosts

  mempool_interco i_interco (
    .clk_i         (clk_i      ),
    .rst_n_i       (rst_n_i    ),
    .hreq_valid_i  (hreq_valid ),
    .hreq_ready_o  (hreq_ready ),
    .hreq_addr_i   (hreq_addr  ),
    .hreq_wen_i    (hreq_wen   ),
    .hreq_wdata_i  (hreq_wdata ),
    .hreq_be_i     (hreq_be    ),
    .hresp_valid_o (hresp_valid),
    .hresp_rdata_o (hresp_rdata),
    .treq_valid_o  (treq_valid ),
    .treq_ready_i  (treq_ready ),
    .treq_addr_o   (treq_addr  ),
    .treq_ini_o    (treq_ini   ),
    .treq_wen_o    (treq_wen   ),
    .treq_wdata_o  (treq_wdata ),
    .treq_be_o     (treq_be    ),
    .tresp_valid_i (tresp_valid),
    .tresp_ini_i   (tresp_ini  ),
    .tresp_rdata_i (tresp_rdata)
  );

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tiles
    mempool_tile i_tile (
      .clk_i         (clk_i         ),
      .rst_n_i       (rst_n_i       ),
      .treq_valid_i  (treq_valid[t] ),
      .treq_ready_o  (treq_ready[t] ),
      .treq_addr_i   (treq_addr[t]  ),
      .treq_ini_i    (treq_ini[t]   ),
      .treq_wen_i    (treq_wen[t]   ),
      .treq_wdata_i  (treq_wdata[t] ),
      .treq_be_i     (treq_be[t]    ),
      .tresp_valid_o (tresp_valid[t]),
      .tresp_ini_o   (tresp_ini[t]  ),
      .tresp_rdata_o (tresp_rdata[t])
    );
  end : gen_tiles

  // Address interleaving needs power-of-two field sizes
  if (NumTiles != 2**$clog2(NumTiles)) begin : gen_chk_tiles
    $fatal(1, "[mempool] The number of tiles must be a power of two.");
  end

  if (NumBanks != 2**$clog2(NumBanks)) begin : gen_chk_banks
    $fatal(1, "[mempool] The number of banks per tile must be a power of two.");
  end

endmodule

`default_nettype wire

/* rtl/mempool_cfg.svh */
/*
 * MemPool cluster sizing. Host, tile and bank counts of the shared TCDM
 */
`ifndef MEMPOOL_CFG_SVH
`define MEMPOOL_CFG_SVH

// Host ports in front of the interconnect
`define MEMPOOL_NUM_HOSTS 2

// Tile count, must be a power of two
`define MEMPOOL_NUM_TILES 2

// Banks in each tile, must be a power of two
`define MEMPOOL_BANKS_PER_TILE 2

// Depth of one bank in words
`define MEMPOOL_WORDS_PER_BANK 64

// Word width, a whole number of bytes
`define MEMPOOL_DATA_WIDTH 32

`endif

/* rtl/mempool_host_port.sv */
/*
 * MemPool host port. Turns a four-phase req/ack access into one
 * valid/ready TCDM request and holds the read data during ack
 */
`timescale 1ns/1ps
`default_nettype none

module mempool_host_port (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Four-phase host side
  input  logic               req_i,
  output logic               ack_o,
  input  logic               wen_i,
  input  mempool_pkg::addr_t addr_i,
  input  mempool_pkg::data_t wdata_i,
  input  mempool_pkg::strb_t be_i,
  output mempool_pkg::data_t rdata_o,
  // TCDM request toward the interconnect
  output logic               hreq_valid_o,
  input  logic               hreq_ready_i,
  output mempool_pkg::addr_t hreq_addr_o,
  output logic               hreq_wen_o,
  output mempool_pkg::data_t hreq_wdata_o,
  output mempool_pkg::strb_t hreq_be_o,
  input  logic               hresp_valid_i,
  input  mempool_pkg::data_t hresp_rdata_i
);

  import mempool_pkg::*;

  typedef enum logic [2:0] {
    StIdle,
    StReq,
    StWait,
    StAck,
    StRelease
  } state_e;

  state_e state_q;
  state_e state_d;
  addr_t  addr_q;
  logic   wen_q;
  data_t  wdata_q;
  strb_t  be_q;
  data_t  rdata_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle:
        if (req_i) state_d = StReq;
      StReq:
        if (hreq_ready_i) state_d = StWait;
      StWait:
        if (hresp_valid_i) state_d = StAck;
      // Hold ack until the host drops req
      StAck:
        if (!req_i) state_d = StRelease;
      StRelease: state_d = StIdle;
      default:   state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request fields, sampled when req is first seen
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && req_i) begin
      addr_q  <= addr_i;
      wen_q   <= wen_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
    if (state_q == StWait && hresp_valid_i) begin
      rdata_q <= hresp_rdata_i;
    end else if (state_q == StRelease) begin
      rdata_q <= '0;
    end
  end

  assign hreq_valid_o = (state_q == StReq);
  assign hreq_addr_o  = addr_q;
  assign hreq_wen_o   = wen_q;
  assign hreq_wdata_o = wdata_q;
  assign hreq_be_o    = be_q;

  assign ack_o   = (state_q == StAck);
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* rtl/mempool_interco.sv */
/*
 * MemPool interconnect. Decodes word-interleaved addresses, grants one
 * host per tile in round-robin order and steers responses back
 */
`timescale 1ns/1ps
`default_nettype none
`include "mempool_cfg.svh"

module mempool_interco (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  // Host side
  input  logic                     [`MEMPOOL_NUM_HOSTS-1:0]     hreq_valid_i,
  output logic                     [`MEMPOOL_NUM_HOSTS-1:0]     hreq_ready_o,
  input  mempool_pkg::addr_t       [`MEMPOOL_NUM_HOSTS-1:0]     hreq_addr_i,
  input  logic                     [`MEMPOOL_NUM_HOSTS-1:0]     hreq_wen_i,
  input  mempool_pkg::data_t       [`MEMPOOL_NUM_HOSTS-1:0]     hreq_wdata_i,
  input  mempool_pkg::strb_t       [`MEMPOOL_NUM_HOSTS-1:0]     hreq_be_i,
  output logic                     [`MEMPOOL_NUM_HOSTS-1:0]     hresp_valid_o,
  output mempool_pkg::data_t       [`MEMPOOL_NUM_HOSTS-1:0]     hresp_rdata_o,
  // Tile side
  output logic                     [`MEMPOOL_NUM_TILES-1:0]     treq_valid_o,
  input  logic                     [`MEMPOOL_NUM_TILES-1:0]     treq_ready_i,
  output mempool_pkg::tile_addr_t  [`MEMPOOL_NUM_TILES-1:0]     treq_addr_o,
  output mempool_pkg::ini_addr_t   [`MEMPOOL_NUM_TILES-1:0]     treq_ini_o,
  output logic                     [`MEMPOOL_NUM_TILES-1:0]     treq_wen_o,
  output mempool_pkg::data_t       [`MEMPOOL_NUM_TILES-1:0]     treq_wdata_o,
  output mempool_pkg::strb_t       [`MEMPOOL_NUM_TILES-1:0]     treq_be_o,
  input  logic                     [`MEMPOOL_NUM_TILES-1:0]     tresp_valid_i,
  input  mempool_pkg::ini_addr_t   [`MEMPOOL_NUM_TILES-1:0]     tresp_ini_i,
  input  mempool_pkg::data_t       [`MEMPOOL_NUM_TILES-1:0]     tresp_rdata_i
);

  import mempool_pkg::*;

  localparam int unsigned NumHosts = `MEMPOOL_NUM_HOSTS;
  localparam int unsigned NumTiles = `MEMPOOL_NUM_TILES;

  logic       [NumHosts-1:0][TileIdxWidth-1:0] tgt_tile;
  tile_addr_t [NumHosts-1:0]                   tgt_addr;
  // Highest-priority host of each tile
  ini_addr_t  [NumTiles-1:0]                   rr_q;
  ini_addr_t  [NumTiles-1:0]                   rr_d;

  // Byte, bank, tile, then row, counting from the LSB
  for (genvar h = 0; h < NumHosts; h++) begin : gen_decode
    assign tgt_tile[h] = hreq_addr_i[h][ByteOffset+BankIdxWidth +: TileIdxWidth];
    assign tgt_addr[h] = {
      hreq_addr_i[h][ByteOffset+BankIdxWidth+TileIdxWidth +: RowWidth],
      hreq_addr_i[h][ByteOffset +: BankIdxWidth]
    };
  end

  always_comb begin
    int unsigned idx;
    treq_valid_o = '0;
    treq_addr_o  = '0;
    treq_ini_o   = '0;
    treq_wen_o   = '0;
    treq_wdata_o = '0;
    treq_be_o    = '0;
    rr_d         = rr_q;
    for (int unsigned t = 0; t < NumTiles; t++) begin
      // Scan hosts starting at the pointer, first match wins
      for (int unsigned k = 0; k < NumHosts; k++) begin
        idx = (rr_q[t] + k) % NumHosts;
        if (!treq_valid_o[t] && hreq_valid_i[idx] &&
            (tgt_tile[idx] == TileIdxWidth'(t))) begin
          treq_valid_o[t] = 1'b1;
          treq_ini_o[t]   = ini_addr_t'(idx);
          treq_addr_o[t]  = tgt_addr[idx];
          treq_wen_o[t]   = hreq_wen_i[idx];
          treq_wdata_o[t] = hreq_wdata_i[idx];
          treq_be_o[t]    = hreq_be_i[idx];
        end
      end
      // Winner moves to lowest priority
      if (treq_valid_o[t] && treq_ready_i[t]) begin
        rr_d[t] = ini_addr_t'((treq_ini_o[t] + 1) % NumHosts);
      end
    end
    // Losers see ready low and keep their request up
    for (int unsigned h = 0; h < NumHosts; h++) begin
      hreq_ready_o[h] = treq_valid_o[tgt_tile[h]] && treq_ready_i[tgt_tile[h]] &&
                        (treq_ini_o[tgt_tile[h]] == ini_addr_t'(h));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  // One outstanding access per host, so at most one tile answers each host
  always_comb begin
    hresp_valid_o = '0;
    hresp_rdata_o = '0;
    for (int unsigned t = 0; t < NumTiles; t++) begin
      if (tresp_valid_i[t]) begin
        hresp_valid_o[tresp_ini_i[t]] = 1'b1;
        hresp_rdata_o[tresp_ini_i[t]] = tresp_rdata_i[t];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/mempool_pkg.sv */
/*
 * MemPool shared types. Byte address, data word, strobes and the
 * host and tile-local indices passed through the interconnect
 */
`default_nettype none
`include "mempool_cfg.svh"

package mempool_pkg;

  // Field widths of the interleaved byte address
  localparam int unsigned BeWidth      = `MEMPOOL_DATA_WIDTH / 8;
  localparam int unsigned ByteOffset   = $clog2(BeWidth);
  localparam int unsigned BankIdxWidth = $clog2(`MEMPOOL_BANKS_PER_TILE);
  localparam int unsigned TileIdxWidth = $clog2(`MEMPOOL_NUM_TILES);
  localparam int unsigned RowWidth     = $clog2(`MEMPOOL_WORDS_PER_BANK);
  localparam int unsigned IniWidth     =
    (`MEMPOOL_NUM_HOSTS > 1) ? $clog2(`MEMPOOL_NUM_HOSTS) : 1;

  typedef logic [31:0]                    addr_t;
  typedef logic [`MEMPOOL_DATA_WIDTH-1:0] data_t;
  typedef logic [BeWidth-1:0]             strb_t;
  typedef logic [IniWidth-1:0]            ini_addr_t;

  // Row in the upper bits, bank index in the lower bits
  typedef logic [RowWidth+BankIdxWidth-1:0] tile_addr_t;

endpackage

`default_nettype wire

/* rtl/mempool_tile.sv */
/*
 * MemPool tile. SRAM banks with byte-enabled writes and a registered
 * one-cycle response tagged with the initiator index
 */
`timescale 1ns/1ps
`default_nettype none
`include "mempool_cfg.svh"

module mempool_tile (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Request from the interconnect
  input  logic                    treq_valid_i,
  output logic                    treq_ready_o,
  input  mempool_pkg::tile_addr_t treq_addr_i,
  input  mempool_pkg::ini_addr_t  treq_ini_i,
  input  logic                    treq_wen_i,
  input  mempool_pkg::data_t      treq_wdata_i,
  input  mempool_pkg::strb_t      treq_be_i,
  // Response, one cycle after acceptance
  output logic                    tresp_valid_o,
  output mempool_pkg::ini_addr_t  tresp_ini_o,
  output mempool_pkg::data_t      tresp_rdata_o
);

  import mempool_pkg::*;

  localparam int unsigned NumBanks = `MEMPOOL_BANKS_PER_TILE;
  localparam int unsigned NumRows  = `MEMPOOL_WORDS_PER_BANK;

  data_t bank_mem [NumBanks][NumRows];

  logic [BankIdxWidth-1:0] bank;
  logic [RowWidth-1:0]     row;
  data_t                   rd_word;
  data_t                   wr_word;
  logic                    valid_q;
  ini_addr_t               ini_q;
  data_t                   rdata_q;

  assign bank = treq_addr_i[BankIdxWidth-1:0];
  assign row  = treq_addr_i[BankIdxWidth +: RowWidth];

  // Tile takes one request every cycle
  assign treq_ready_o = 1'b1;

  assign rd_word = bank_mem[bank][row];

  // Merge enabled bytes into the stored word
  always_comb begin
    wr_word = rd_word;
    for (int unsigned b = 0; b < BeWidth; b++) begin
      if (treq_be_i[b]) begin
        wr_word[8*b +: 8] = treq_wdata_i[8*b +: 8];
      end
    end
  end

  // Old data is returned on a write
  always_ff @(posedge clk_i) begin
    if (treq_valid_i) begin
      rdata_q <= rd_word;
      ini_q   <= treq_ini_i;
      if (treq_wen_i) begin
        bank_mem[bank][row] <= wr_word;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= treq_valid_i && treq_ready_o;
    end
  end

  assign tresp_valid_o = valid_q;
  assign tresp_ini_o   = ini_q;
  assign tresp_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the MemPool testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_mempool -f list.f &&
  ./obj_dir/Vtb_mempool > sim.log 2>&1 ||
  { cat sim.log 2>/dev/null; echo "build or simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
exit 0

/* test/mempool_asserts.sv */
/*
 * MemPool handshake checks. Four-phase ack behavior and the
 * arbitration bound on each host request
 */
`timescale 1ns/1ps
`default_nettype none
`include "mempool_cfg.svh"

module mempool_asserts (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic [`MEMPOOL_NUM_HOSTS-1:0] req_i,
  input logic [`MEMPOOL_NUM_HOSTS-1:0] ack_i,
  input logic [`MEMPOOL_NUM_HOSTS-1:0] hreq_valid_i,
  input logic [`MEMPOOL_NUM_HOSTS-1:0] hreq_ready_i
);

  localparam int unsigned NumHosts = `MEMPOOL_NUM_HOSTS;

  for (genvar h = 0; h < NumHosts; h++) begin : gen_host
    // Consecutive stalled cycles before this one
    int unsigned stall_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        stall_q <= 0;
      end else if (hreq_valid_i[h] && !hreq_ready_i[h]) begin
        stall_q <= stall_q + 1;
      end else begin
        stall_q <= 0;
      end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) $rose(ack_i[h]) |-> req_i[h])
      else $error("host %0d raised ack without a request", h);

    assert property (@(posedge clk_i) disable iff (!rst_n_i) $fell(req_i[h]) |=> !ack_i[h])
      else $error("host %0d kept ack high after req fell", h);

    // Round-robin grant within NumHosts cycles
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (hreq_valid_i[h] && !hreq_ready_i[h]) |-> (stall_q < NumHosts - 1))
      else $error("host %0d request not granted within %0d cycles", h, NumHosts);
  end

endmodule

bind mempool mempool_asserts i_mempool_asserts (
  .clk_i        (clk_i     ),
  .rst_n_i      (rst_n_i   ),
  .req_i        (req_i     ),
  .ack_i        (ack_o     ),
  .hreq_valid_i (hreq_valid),
  .hreq_ready_i (hreq_ready)
);

`default_nettype wire

/* test/tb_mempool.sv */
/*
 * MemPool testbench. Random four-phase traffic on both hosts, checked
 * against a byte-enabled reference model of the interleaved memory
 */
`timescale 1ns/1ps
`default_nettype none
`include "mempool_cfg.svh"

module tb_mempool;

  import mempool_pkg::*;

  localparam int unsigned NumHosts  = `MEMPOOL_NUM_HOSTS;
  localparam int unsigned NumTiles  = `MEMPOOL_NUM_TILES;
  localparam int unsigned NumBanks  = `MEMPOOL_BANKS_PER_TILE;
  localparam int unsigned NumRows   = `MEMPOOL_WORDS_PER_BANK;
  localparam int unsigned WordBytes = `MEMPOOL_DATA_WIDTH / 8;
  localparam int unsigned MemBytes  = NumTiles * NumBanks * NumRows * WordBytes;
  // Byte, bank, tile, then row, counting from the LSB
  localparam int unsigned BankLsb   = $clog2(WordBytes);
  localparam int unsigned TileLsb   = BankLsb + $clog2(NumBanks);
  localparam int unsigned RowLsb    = TileLsb + $clog2(NumTiles);
  localparam int unsigned TimeoutCycles = 100;

  logic                  clk;
  logic                  rst_n;
  logic [NumHosts-1:0]   req;
  logic [NumHosts-1:0]   ack;
  logic [NumHosts-1:0]   wen;
  addr_t [NumHosts-1:0]  addr;
  data_t [NumHosts-1:0]  wdata;
  strb_t [NumHosts-1:0]  be;
  data_t [NumHosts-1:0]  rdata;

  data_t model [NumTiles][NumBanks][NumRows];
  data_t exp_data [NumHosts];
  bit    exp_rd [NumHosts];
  logic [NumHosts-1:0] ack_prev;
  int unsigned err_cnt;
  int unsigned chk_cnt;
  int unsigned acc_cnt;

  mempool i_mempool (
    .clk_i   (clk  ),
    .rst_n_i (rst_n),
    .req_i   (req  ),
    .ack_o   (ack  ),
    .wen_i   (wen  ),
    .addr_i  (addr ),
    .wdata_i (wdata),
    .be_i    (be   ),
    .rdata_o (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Upper address bits drop out, so addresses alias modulo the memory size
  function automatic int unsigned field(addr_t a, int unsigned lsb, int unsigned n);
    return (a >> lsb) % n;
  endfunction

  function automatic data_t ref_read(addr_t a);
    return model[field(a, TileLsb, NumTiles)][field(a, BankLsb, NumBanks)]
                [field(a, RowLsb, NumRows)];
  endfunction

  task automatic model_write(addr_t a, data_t d, strb_t s);
    data_t w;
    w = ref_read(a);
    for (int unsigned b = 0; b < WordBytes; b++) begin
      if (s[b]) w[8*b +: 8] = d[8*b +: 8];
    end
    model[field(a, TileLsb, NumTiles)][field(a, BankLsb, NumBanks)]
         [field(a, RowLsb, NumRows)] = w;
  endtask

  function automatic addr_t rand_word(int unsigned lo, int unsigned span);
    return addr_t'(lo + ($urandom % (span / WordBytes)) * WordBytes);
  endfunction

  task automatic end_run(bit timed_out);
    $display("checks %0d, errors %0d, accesses %0d", chk_cnt, err_cnt, acc_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // Polls on the falling edge, where ack is stable
  task automatic wait_ack(int unsigned h, logic level);
    int unsigned cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (ack[h] !== level && cnt < TimeoutCycles);
    if (ack[h] !== level) begin
      $display("host %0d: ack did not go to %0b within %0d cycles", h, level, TimeoutCycles);
      end_run(1'b1);
    end
  endtask

  // One full four-phase access; the model is updated when it is issued
  task automatic host_access(int unsigned h, bit wr, addr_t a, data_t d, strb_t s);
    if (wr) model_write(a, d, s);
    else exp_data[h] = ref_read(a);
    exp_rd[h] = !wr;
    @(posedge clk);
    req[h]   <= 1'b1;
    wen[h]   <= wr;
    addr[h]  <= a;
    wdata[h] <= d;
    be[h]    <= s;
    wait_ack(h, 1'b1);
    @(posedge clk);
    req[h] <= 1'b0;
    wait_ack(h, 1'b0);
    acc_cnt++;
  endtask

  // Each host keeps to its own share of the rows
  task automatic host_traffic(int unsigned h);
    addr_t a;
    repeat (100) begin
      a = rand_word(h * (MemBytes / NumHosts), MemBytes / NumHosts);
      host_access(h, 1'($urandom), a, data_t'($urandom), strb_t'($urandom));
    end
  endtask

  // Read data is checked on the rising edge of ack
  always @(negedge clk) begin
    for (int h = 0; h < NumHosts; h++) begin
      if (ack[h] && !ack_prev[h] && exp_rd[h]) begin
        chk_cnt++;
        assert (rdata[h] === exp_data[h]) else begin
          err_cnt++;
          $display("error %0t: host %0d addr 0x%08h read 0x%08h, expected 0x%08h",
                   $time, h, addr[h], rdata[h], exp_data[h]);
        end
      end
      ack_prev[h] = ack[h];
    end
  end

  initial begin
    addr_t a;
    addr_t far_a;
    void'($urandom(32'h85e3));
    rst_n    = 1'b0;
    req      = '0;
    wen      = '0;
    addr     = '0;
    wdata    = '0;
    be       = '0;
    ack_prev = '0;
    err_cnt  = 0;
    chk_cnt  = 0;
    acc_cnt  = 0;
    for (int h = 0; h < NumHosts; h++) begin
      exp_rd[h] = 1'b0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Idle hosts never see ack
    repeat (8) begin
      @(negedge clk);
      chk_cnt++;
      assert (ack === '0) else begin
        err_cnt++;
        $display("error %0t: ack 0b%b high with no request", $time, ack);
      end
    end

    // Every word of every tile and bank, written then read back
    for (int unsigned w = 0; w < MemBytes / WordBytes; w++) begin
      host_access(w % NumHosts, 1'b1, addr_t'(w * WordBytes), data_t'($urandom), '1);
    end
    for (int unsigned w = 0; w < MemBytes / WordBytes; w++) begin
      host_access((w + 1) % NumHosts, 1'b0, addr_t'(w * WordBytes), '0, '0);
    end

    // Partial byte enables
    repeat (100) begin
      a = rand_word(0, MemBytes);
      host_access(0, 1'b1, a, data_t'($urandom), strb_t'($urandom));
      host_access(1, 1'b0, a, '0, '0);
    end

    fork
      host_traffic(0);
      host_traffic(1);
    join

    // Aliased addresses above the memory size
    repeat (20) begin
      a = rand_word(0, MemBytes);
      far_a = a + MemBytes * (1 + $urandom % 1000);
      host_access(0, 1'b0, far_a, '0, '0);
      host_access(1, 1'b1, far_a, data_t'($urandom), '1);
      host_access(0, 1'b0, a, '0, '0);
    end

    repeat (4) @(posedge clk);
    end_run(1'b0);
  end

endmodule

`default_nettype wire
